/* logic/mult_consts.svh */
// widths and counts for the booth multiplier, included by the package and the stage modules
`ifndef MULT_CONSTS_SVH
`define MULT_CONSTS_SVH

// operand widths before zero extension
`define MULT_A_WIDTH 53
`define MULT_B_WIDTH 27

// radix-4 recoding of the 28-bit extended multiplier
`define MULT_NUM_DIGITS 14

// one row per digit plus a row for the last negate correction
`define MULT_NUM_ROWS 15

// partial product row width
`define MULT_ROW_WIDTH 82

// carry-save output word width
`define MULT_PAIR_WIDTH 84

// final product width
`define MULT_PROD_WIDTH 80

// decode, compress, add
`define MULT_LATENCY 3

`endif

/* logic/mult_pkg.sv */
// shared vector types and packed structs for the multiplier pipeline, referenced by scoped name
`include "mult_consts.svh"

package mult_pkg;

  // ==========================================================================
  // plain vectors
  // ==========================================================================

  // multiplicand as it arrives
  typedef logic [`MULT_A_WIDTH-1:0] a_t;

  // multiplier as it arrives
  typedef logic [`MULT_B_WIDTH-1:0] b_t;

  // one selected partial product
  // one bit wider than a, room for 2A
  typedef logic [`MULT_A_WIDTH:0] pp_t;

  // one offset row into the tree
  typedef logic [`MULT_ROW_WIDTH-1:0] row_t;

  // half of the carry-save result
  typedef logic [`MULT_PAIR_WIDTH-1:0] pair_word_t;

  // resolved product
  typedef logic [`MULT_PROD_WIDTH-1:0] prod_t;

  // ==========================================================================
  // grouped payloads
  // ==========================================================================

  // operand pair entering the decode stage
  typedef struct packed {
    a_t a;
    b_t b;
  } mult_req_t;

  // all rows between decode and tree
  typedef struct packed {
    row_t [`MULT_NUM_ROWS-1:0] row;
  } pp_rows_t;

  // redundant result, sum + carry gives the product
  typedef struct packed {
    pair_word_t sum;
    pair_word_t carry;
  } csa_pair_t;

endpackage

/* logic/booth_digit_sel.sv */
// recodes one radix-4 booth digit and selects the partial product, instantiated per digit by booth_decode
`timescale 1ns/1ps
`include "mult_consts.svh"

module booth_digit_sel (
  input  mult_pkg::pp_t multiplicand,
  input  logic [2:0]    code,
  output mult_pkg::pp_t product,
  output logic [1:0]    h,
  output logic          sn
);

  // magnitude before the sign is applied
  mult_pkg::pp_t sel;
  // digit is negative
  logic neg;

  always_comb begin
    sel = '0;
    neg = 1'b0;
    case (code)
      // +A
      3'b001, 3'b010: begin
        sel = multiplicand;
      end
      // +2A
      3'b011: begin
        sel = {multiplicand[`MULT_A_WIDTH-1:0], 1'b0};
      end
      // -2A
      3'b100: begin
        sel = {multiplicand[`MULT_A_WIDTH-1:0], 1'b0};
        neg = 1'b1;
      end
      // -A
      3'b101, 3'b110: begin
        sel = multiplicand;
        neg = 1'b1;
      end
      // 000 and 111 select zero
      default: begin
        sel = '0;
        neg = 1'b0;
      end
    endcase
  end

  // one's complement here
  // the +1 rides on the next row as h
  assign product = neg ? ~sel : sel;
  assign h       = {1'b0, neg};

  // inverted sign for sign-extension prevention
  // 2A can fill the top bit, so the sign comes from the digit
  assign sn = ~neg;

endmodule

/* logic/booth_decode.sv */
// decode stage, recodes the multiplier and registers the 15 offset partial product rows
`timescale 1ns/1ps
`include "mult_consts.svh"

module booth_decode (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                in_vld,
  input  mult_pkg::mult_req_t in_req,
  output mult_pkg::pp_rows_t  rows,
  output logic                rows_vld
);

  // ==========================================================================
  // operand extension
  // ==========================================================================

  // both operands unsigned
  // one zero bit on top keeps them positive
  mult_pkg::pp_t                  multiplicand;
  logic [`MULT_B_WIDTH:0]         mult_src;
  // recoding window source
  // implicit bit -1 at the bottom
  logic [`MULT_B_WIDTH+1:0]       code_src;

  mult_pkg::pp_t                  pp [`MULT_NUM_DIGITS];
  logic [1:0]                     h  [`MULT_NUM_DIGITS];
  logic [`MULT_NUM_DIGITS-1:0]    sn;
  mult_pkg::pp_rows_t             rows_d;

  assign multiplicand = {1'b0, in_req.a};
  assign mult_src     = {1'b0, in_req.b};
  assign code_src     = {mult_src, 1'b0};

  // ==========================================================================
  // digit select and row build
  // ==========================================================================

  for (genvar i = 0; i < `MULT_NUM_DIGITS; i++) begin : g_digit
    // digit i looks at multiplier bits 2i+1 .. 2i-1
    booth_digit_sel u_sel (
      .multiplicand (multiplicand),
      .code         (code_src[2*i+2:2*i]),
      .product      (pp[i]),
      .h            (h[i]),
      .sn           (sn[i])
    );

    if (i == 0) begin : g_first
      // first row carries the full sign-extension prefix
      assign rows_d.row[0] = mult_pkg::row_t'({sn[0], ~sn[0], ~sn[0], pp[0]});
    end else begin : g_rest
      // h of the previous digit fills the two low slots
      // product lands at weight 2i
      assign rows_d.row[i] =
        mult_pkg::row_t'({1'b1, sn[i], pp[i], h[i-1]}) << (2 * (i - 1));
    end
  end

  // last correction has no digit of its own
  assign rows_d.row[`MULT_NUM_ROWS-1] =
    mult_pkg::row_t'(h[`MULT_NUM_DIGITS-1]) << (2 * (`MULT_NUM_DIGITS - 1));

  // ==========================================================================
  // stage register
  // ==========================================================================

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rows_vld <= 1'b0;
    end else begin
      rows_vld <= in_vld;
    end
  end

  // payload only moves with a strobe
  always_ff @(posedge clk) begin
    if (in_vld) begin
      rows <= rows_d;
    end
  end

endmodule

/* logic/compressor_4to2.sv */
// width-generic 4:2 carry-save compressor, used at every level of the csa tree
`timescale 1ns/1ps

module compressor_4to2 #(
  parameter int WIDTH = 82
) (
  input  logic [WIDTH-1:0] in0,
  input  logic [WIDTH-1:0] in1,
  input  logic [WIDTH-1:0] in2,
  input  logic [WIDTH-1:0] in3,
  output logic [WIDTH-1:0] sum,
  output logic [WIDTH-1:0] carry
);

  // majority of the first three inputs
  logic [WIDTH-1:0] cout;
  // parity of all four inputs
  logic [WIDTH-1:0] par;
  // internal carry moved up one column
  // top bit falls off
  logic [WIDTH-1:0] cin;

  assign cout = (in0 & in1) | (in1 & in2) | (in0 & in2);
  assign par  = in0 ^ in1 ^ in2 ^ in3;
  assign cin  = {cout[WIDTH-2:0], 1'b0};

  assign sum = par ^ cin;

  // carry select on parity
  // odd picks the incoming carry, even picks in3
  assign carry = (par & cin) | (~par & in3);

  // carry output has weight 2
  // caller shifts it before the next level

endmodule

/* logic/csa_tree.sv */
// execute stage, compresses the 15 rows to a registered 84-bit carry-save pair
`timescale 1ns/1ps
`include "mult_consts.svh"

module csa_tree (
  input  logic                clk,
  input  logic                rst_n,
  input  mult_pkg::pp_rows_t  rows,
  input  logic                rows_vld,
  output mult_pkg::csa_pair_t pair,
  output logic                pair_vld
);

  // level 1 results, slot 3 from the inline 3:2
  mult_pkg::row_t s0 [4];
  mult_pkg::row_t c0 [4];
  // level 2 results
  mult_pkg::row_t s1 [2];
  mult_pkg::row_t c1 [2];
  // level 3 works one bit wider
  logic [`MULT_ROW_WIDTH:0] p2 [4];
  logic [`MULT_ROW_WIDTH:0] s2;
  logic [`MULT_ROW_WIDTH:0] c2;
  mult_pkg::csa_pair_t      pair_d;

  // ==========================================================================
  // level 1, 15 rows to 8
  // ==========================================================================

  for (genvar g = 0; g < 3; g++) begin : g_lvl1
    compressor_4to2 #(.WIDTH(`MULT_ROW_WIDTH)) u_cmp (
      .in0   (rows.row[4*g]),
      .in1   (rows.row[4*g+1]),
      .in2   (rows.row[4*g+2]),
      .in3   (rows.row[4*g+3]),
      .sum   (s0[g]),
      .carry (c0[g])
    );
  end

  // rows 12..14 through a plain full adder
  assign s0[3] = rows.row[12] ^ rows.row[13] ^ rows.row[14];
  assign c0[3] = (rows.row[12] & rows.row[13]) |
                 (rows.row[12] & rows.row[14]) |
                 (rows.row[13] & rows.row[14]);

  // ==========================================================================
  // level 2, 8 to 4
  // ==========================================================================

  for (genvar g = 0; g < 2; g++) begin : g_lvl2
    // carries shifted into their weight
    compressor_4to2 #(.WIDTH(`MULT_ROW_WIDTH)) u_cmp (
      .in0   (s0[2*g]),
      .in1   ({c0[2*g][`MULT_ROW_WIDTH-2:0], 1'b0}),
      .in2   (s0[2*g+1]),
      .in3   ({c0[2*g+1][`MULT_ROW_WIDTH-2:0], 1'b0}),
      .sum   (s1[g]),
      .carry (c1[g])
    );
  end

  // ==========================================================================
  // level 3, 4 to 2 at 83 bits
  // ==========================================================================

  // sums sign-extended, carries shifted up with no loss
  assign p2[0] = {s1[0][`MULT_ROW_WIDTH-1], s1[0]};
  assign p2[1] = {c1[0], 1'b0};
  assign p2[2] = {s1[1][`MULT_ROW_WIDTH-1], s1[1]};
  assign p2[3] = {c1[1], 1'b0};

  compressor_4to2 #(.WIDTH(`MULT_ROW_WIDTH + 1)) u_lvl3 (
    .in0   (p2[0]),
    .in1   (p2[1]),
    .in2   (p2[2]),
    .in3   (p2[3]),
    .sum   (s2),
    .carry (c2)
  );

  // widen to the 84-bit pair
  assign pair_d.sum   = {s2[`MULT_ROW_WIDTH], s2};
  assign pair_d.carry = {c2, 1'b0};

  // stage register
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pair_vld <= 1'b0;
    end else begin
      pair_vld <= rows_vld;
    end
  end

  always_ff @(posedge clk) begin
    if (rows_vld) begin
      pair <= pair_d;
    end
  end

endmodule

/* logic/product_adder.sv */
// result stage, resolves the carry-save pair into the product and forwards the pair
`timescale 1ns/1ps
`include "mult_consts.svh"

module product_adder (
  input  logic                clk,
  input  logic                rst_n,
  input  mult_pkg::csa_pair_t pair,
  input  logic                pair_vld,
  output logic                out_vld,
  output mult_pkg::csa_pair_t out_pair,
  output mult_pkg::prod_t     out_prod
);

  // full-width add
  // wraps modulo 2^84
  mult_pkg::pair_word_t total;

  assign total = pair.sum + pair.carry;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_vld <= 1'b0;
    end else begin
      out_vld <= pair_vld;
    end
  end

  // upper bits of total are zero for a valid pair
  always_ff @(posedge clk) begin
    if (pair_vld) begin
      out_prod <= total[`MULT_PROD_WIDTH-1:0];
      // pair kept for a downstream fused add
      out_pair <= pair;
    end
  end

endmodule

/* logic/mult_53x27_top.sv */
// top level of the three-stage 53x27 booth multiplier, wires decode, tree and adder
`timescale 1ns/1ps

module mult_53x27_top (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                in_vld,
  input  mult_pkg::mult_req_t in_req,
  output logic                out_vld,
  output mult_pkg::csa_pair_t out_pair,
  output mult_pkg::prod_t     out_prod
);

  // ==========================================================================
  // stage links
  // ==========================================================================

  // decode to tree
  mult_pkg::pp_rows_t  rows;
  logic                rows_vld;
  // tree to adder
  mult_pkg::csa_pair_t pair;
  logic                pair_vld;

  // stage 1
  // booth recode and row build
  booth_decode u_decode (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_vld   (in_vld),
    .in_req   (in_req),
    .rows     (rows),
    .rows_vld (rows_vld)
  );

  // stage 2
  // 15 rows down to a carry-save pair
  csa_tree u_tree (
    .clk      (clk),
    .rst_n    (rst_n),
    .rows     (rows),
    .rows_vld (rows_vld),
    .pair     (pair),
    .pair_vld (pair_vld)
  );

  // stage 3
  // final add, pair forwarded alongside
  product_adder u_adder (
    .clk      (clk),
    .rst_n    (rst_n),
    .pair     (pair),
    .pair_vld (pair_vld),
    .out_vld  (out_vld),
    .out_pair (out_pair),
    .out_prod (out_prod)
  );

endmodule

/* testbench/mult_chk.sv */
// bound assertion checker for the multiplier top level, watches strobe timing and reset
`timescale 1ns/1ps

module mult_chk (
  input logic            clk,
  input logic            rst_n,
  input logic            in_vld,
  input logic            out_vld,
  input mult_pkg::prod_t out_prod
);

  // failures seen so far, read by the testbench verdict
  int fail_count = 0;

  // strobe leaves three edges after it entered
  // only once reset has been high for the whole trip
  a_latency: assert property (
    @(posedge clk) ($past(rst_n, 1) && $past(rst_n, 2) && $past(rst_n, 3))
      |-> (out_vld == $past(in_vld, 3))
  ) else begin
    fail_count++;
    $error("out_vld does not follow in_vld by three cycles");
  end

  // a valid product is fully known
  a_prod_known: assert property (
    @(posedge clk) out_vld |-> !$isunknown(out_prod)
  ) else begin
    fail_count++;
    $error("out_prod has unknown bits while out_vld is high");
  end

  // reset flushes the strobe
  a_reset_clears: assert property (
    @(posedge clk) !$past(rst_n) |-> !out_vld
  ) else begin
    fail_count++;
    $error("out_vld is high in the cycle after reset");
  end

endmodule

bind mult_53x27_top mult_chk u_chk (
  .clk      (clk),
  .rst_n    (rst_n),
  .in_vld   (in_vld),
  .out_vld  (out_vld),
  .out_prod (out_prod)
);

/* testbench/mult_tb.sv */
// testbench for the 53x27 booth multiplier, random and corner operands checked against a model
`timescale 1ns/1ps
`include "mult_consts.svh"

module mult_tb;

  localparam int RESET_CYCLES = 8;
  localparam int NUM_RANDOM   = 400;
  localparam int NUM_CORNER   = 7;
  localparam int NUM_FLUSH    = 30;
  localparam int MAX_GAP      = 3;
  localparam int MARGIN       = 60;
  // every op plus worst-case gaps, resets and drain waits
  localparam int TOTAL_OPS    = NUM_RANDOM + NUM_CORNER + NUM_FLUSH;
  localparam int IDLE_CYCLES  = (NUM_RANDOM + NUM_FLUSH) * MAX_GAP + 3 * RESET_CYCLES + 40;
  localparam int WATCHDOG_NS  = (TOTAL_OPS + IDLE_CYCLES + `MULT_LATENCY + MARGIN) * 4;

  logic                clk = 1'b0;
  logic                rst_n;
  logic                in_vld;
  mult_pkg::mult_req_t in_req;
  logic                out_vld;
  mult_pkg::csa_pair_t out_pair;
  mult_pkg::prod_t     out_prod;

  // model state, one entry per accepted strobe
  mult_pkg::prod_t exp_q [$];
  int              cyc_q [$];
  string           name_q [$];

  mult_pkg::prod_t front_prod;
  int              front_cyc;
  string           front_name;
  string           cur_name = "idle";
  logic [63:0]     rng = 64'd16376;
  int              cyc = 0;
  int              value_errs = 0;
  int              proto_errs = 0;
  int              assert_errs;

  mult_53x27_top u_dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_vld   (in_vld),
    .in_req   (in_req),
    .out_vld  (out_vld),
    .out_pair (out_pair),
    .out_prod (out_prod)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  function automatic logic [63:0] xorshift(input logic [63:0] s);
    logic [63:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 7;
    x ^= x << 17;
    return x;
  endfunction

  task automatic check_prod(input string name, input mult_pkg::prod_t exp,
                            input mult_pkg::prod_t act);
    if (act !== exp) begin
      value_errs++;
      $display("FAILED %s product expected %h actual %h", name, exp, act);
    end
  endtask

  // whole pair resolves to the zero-extended product
  task automatic check_pair(input string name, input mult_pkg::csa_pair_t act,
                            input mult_pkg::prod_t exp);
    mult_pkg::pair_word_t total;
    mult_pkg::pair_word_t exp_full;
    total    = act.sum + act.carry;
    exp_full = mult_pkg::pair_word_t'(exp);
    if (total !== exp_full) begin
      value_errs++;
      $display("FAILED %s pair expected %h actual %h", name, exp_full, total);
    end
  endtask

  // ==========================================================================
  // monitor, samples at the falling edge where everything is settled
  // ==========================================================================

  always @(negedge clk) begin
    // results first, the first reset cycle may still show an older one
    if (out_vld === 1'b1) begin
      if (exp_q.size() == 0) begin
        proto_errs++;
        $display("out_vld is high at cycle %0d with no operation pending", cyc);
      end else begin
        front_prod = exp_q.pop_front();
        front_cyc  = cyc_q.pop_front();
        front_name = name_q.pop_front();
        if (cyc - front_cyc != `MULT_LATENCY) begin
          proto_errs++;
          $display("result for %s came %0d cycles after its input, not %0d",
                   front_name, cyc - front_cyc, `MULT_LATENCY);
        end
        check_prod(front_name, front_prod, out_prod);
        check_pair(front_name, out_pair, front_prod);
      end
    end
    // overdue results never showed up
    while (cyc_q.size() != 0 && cyc - cyc_q[0] > `MULT_LATENCY) begin
      proto_errs++;
      $display("result for %s issued at cycle %0d never appeared", name_q[0], cyc_q[0]);
      front_prod = exp_q.pop_front();
      front_cyc  = cyc_q.pop_front();
      front_name = name_q.pop_front();
    end
    if (rst_n === 1'b1) begin
      if (in_vld === 1'b1) begin
        // model product, plain a times b
        exp_q.push_back(mult_pkg::prod_t'(in_req.a) * mult_pkg::prod_t'(in_req.b));
        cyc_q.push_back(cyc);
        name_q.push_back(cur_name);
      end
    end else begin
      // in-flight work is dropped by reset
      exp_q.delete();
      cyc_q.delete();
      name_q.delete();
    end
  end

  // ==========================================================================
  // stimulus tasks
  // ==========================================================================

  task automatic apply_op(input mult_pkg::a_t a, input mult_pkg::b_t b, input string name);
    @(posedge clk);
    #0.5;
    in_vld   = 1'b1;
    in_req.a = a;
    in_req.b = b;
    cur_name = name;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #0.5;
      in_vld = 1'b0;
    end
  endtask

  task automatic apply_reset(input int n);
    @(posedge clk);
    #0.5;
    in_vld = 1'b0;
    rst_n  = 1'b0;
    repeat (n) @(posedge clk);
    #0.5;
    rst_n = 1'b1;
  endtask

  task automatic run_random(input int count, input bit with_gaps, input string name);
    mult_pkg::a_t a;
    mult_pkg::b_t b;
    for (int i = 0; i < count; i++) begin
      rng = xorshift(rng);
      a   = rng[`MULT_A_WIDTH-1:0];
      rng = xorshift(rng);
      b   = rng[`MULT_B_WIDTH-1:0];
      apply_op(a, b, name);
      if (with_gaps) begin
        // two low bits give a gap of 0 to MAX_GAP
        rng = xorshift(rng);
        idle_cycles(int'(rng[1:0]));
      end
    end
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("timeout, the run did not finish within %0d ns", WATCHDOG_NS);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    rst_n  = 1'b0;
    in_vld = 1'b0;
    in_req = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #0.5;
    rst_n = 1'b1;
    idle_cycles(2);

    // corner operands, back to back
    apply_op('0, '0, "zero by zero");
    apply_op('1, '1, "all ones");
    apply_op('1, mult_pkg::b_t'({14{2'b01}}), "b alternating 01");
    apply_op(53'h1234_5678_9abc_d, mult_pkg::b_t'({14{2'b10}}), "b alternating 10");
    apply_op('1, mult_pkg::b_t'({7{4'b0110}}), "b codes 011 and 100");
    apply_op({1'b1, {(`MULT_A_WIDTH-1){1'b0}}}, '1, "a top bit");
    apply_op({1'b1, {(`MULT_A_WIDTH-1){1'b0}}}, mult_pkg::b_t'({7{4'b0110}}),
             "a top bit with booth codes");
    idle_cycles(4);

    run_random(NUM_RANDOM / 2, 1'b0, "random back to back");
    run_random(NUM_RANDOM / 2, 1'b1, "random with gaps");
    idle_cycles(2);

    // reset lands while operations are still in the pipeline
    run_random(5, 1'b0, "flushed by reset");
    apply_reset(RESET_CYCLES);
    idle_cycles(4);
    run_random(NUM_FLUSH - 5, 1'b1, "after mid-run reset");

    idle_cycles(1);
    while (exp_q.size() != 0) @(negedge clk);
    // catch any stray strobe
    idle_cycles(`MULT_LATENCY + 2);

    assert_errs = u_dut.u_chk.fail_count;
    $display("errors: value %0d, protocol %0d, assertion %0d",
             value_errs, proto_errs, assert_errs);
    if (value_errs == 0 && proto_errs == 0 && assert_errs == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* compile.f */
+incdir+logic
logic/mult_pkg.sv
logic/booth_digit_sel.sv
logic/booth_decode.sv
logic/compressor_4to2.sv
logic/csa_tree.sv
logic/product_adder.sv
logic/mult_53x27_top.sv
testbench/mult_chk.sv
testbench/mult_tb.sv

/* run.sh */
#!/bin/sh
# builds the multiplier testbench with verilator, runs it and checks the verdict
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f compile.f \
  --top-module mult_tb \
  -Mdir obj_dir

out=$(./obj_dir/Vmult_tb)
echo "$out"
echo "$out" | grep -q "^TEST OK$"
